/* src/term_defines.svh */
`ifndef TERM_DEFINES_SVH
`define TERM_DEFINES_SVH

// screen geometry
`define TB_COLUMNS    16
`define TB_LINES      8

// one cell is {attribute, character}
`define TB_CELL_WIDTH 16
`define TB_LINE_WIDTH (`TB_COLUMNS * `TB_CELL_WIDTH)

// index widths, must cover TB_LINES and TB_COLUMNS
`define TB_ROW_WIDTH  3
`define TB_COL_WIDTH  4

// space, default attribute 07
`define TB_BLANK_CELL 16'h0720

`endif

/* src/term_pkg.sv */
`include "term_defines.svh"

package term_pkg;

	typedef logic [`TB_CELL_WIDTH-1:0] cell_t;  // attr in high byte, char in low byte
	typedef logic [`TB_LINE_WIDTH-1:0] line_t;  // one text line, also the RAM word
	typedef logic [`TB_ROW_WIDTH-1:0]  row_t;
	typedef logic [`TB_COL_WIDTH-1:0]  col_t;
	typedef logic [7:0]                count_t; // command parameter Pn
	typedef logic [7:0]                char_t;
	typedef logic [7:0]                attr_t;

	// decoded terminal commands
	typedef enum logic [2:0] {
		PUT_CHAR,
		ERASE_LINE,
		DELETE_CHARS,
		ERASE_DISPLAY,
		INSERT_LINES,
		DELETE_LINES
	} cmd_t;

	// editor FSM
	typedef enum logic [3:0] {
		ST_INIT,        // set up the power-on clear
		ST_IDLE,
		ST_LINE_RD,     // line edit, read request
		ST_LINE_WAIT,   // line edit, wait for data
		ST_LINE_WR,     // line edit, write back
		ST_SCROLL_RD,   // scroll, read source line
		ST_SCROLL_WAIT,
		ST_SCROLL_WR,   // scroll, write destination line
		ST_FILL         // blank a range of lines
	} edit_state_t;

endpackage

/* src/text_ram_if.sv */
`timescale 1ns/100ps
`include "term_defines.svh"

// one client's port onto the shared line RAM
interface text_ram_if;
	logic            req;    // held until gnt
	logic            we;
	term_pkg::row_t  addr;
	term_pkg::line_t wdata;
	logic            gnt;    // access performed this cycle
	logic            rvalid; // one cycle after a granted read
	term_pkg::line_t rdata;

	modport client (
		output req, we, addr, wdata,
		input  gnt, rvalid, rdata
	);

	modport arbiter (
		input  req, we, addr, wdata,
		output gnt, rvalid, rdata
	);
endinterface

/* src/text_ram.sv */
`timescale 1ns/100ps
`include "term_defines.svh"

module text_ram (
	input  logic            clk,
	input  logic            we,
	input  term_pkg::row_t  addr,
	input  term_pkg::line_t wdata,
	output term_pkg::line_t rdata
);

	term_pkg::line_t mem [`TB_LINES];

	// registered read, old data on a write to the same line
	always_ff @(posedge clk)
	begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

/* src/text_ram_arbiter.sv */
`timescale 1ns/100ps
`include "term_defines.svh"

module text_ram_arbiter (
	input  logic            clk,
	input  logic            rst,
	text_ram_if.arbiter     edit,
	text_ram_if.arbiter     scan,
	output logic            ram_we,
	output term_pkg::row_t  ram_addr,
	output term_pkg::line_t ram_wdata,
	input  term_pkg::line_t ram_rdata
);

	logic last_scan; // scanner owned the last contended grant
	logic edit_rd_q; // read issued for the editor last cycle
	logic scan_rd_q;

	// a lone request wins at once, a tie goes to whoever waited
	assign edit.gnt = edit.req && (!scan.req || last_scan);
	assign scan.gnt = scan.req && (!edit.req || !last_scan);

	assign ram_we    = (edit.gnt && edit.we) || (scan.gnt && scan.we);
	assign ram_addr  = scan.gnt ? scan.addr : edit.addr;
	assign ram_wdata = scan.gnt ? scan.wdata : edit.wdata;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			last_scan <= 1'b1; // editor goes first after reset
			edit_rd_q <= 1'b0;
			scan_rd_q <= 1'b0;
		end
		else
		begin
			if (edit.gnt)
				last_scan <= 1'b0;
			else if (scan.gnt)
				last_scan <= 1'b1;
			edit_rd_q <= edit.gnt && !edit.we;
			scan_rd_q <= scan.gnt && !scan.we;
		end
	end

	// data goes to both, only the owner sees rvalid
	assign edit.rvalid = edit_rd_q;
	assign scan.rvalid = scan_rd_q;
	assign edit.rdata  = ram_rdata;
	assign scan.rdata  = ram_rdata;

	a_single_grant: assert property (@(posedge clk) disable iff (rst)
		!(edit.gnt && scan.gnt));

	// read data only ever follows a granted read on the RAM port
	a_rvalid_after_read: assert property (@(posedge clk) disable iff (rst)
		(edit.rvalid || scan.rvalid) |-> $past((edit.gnt || scan.gnt) && !ram_we));

endmodule

/* src/line_edit_data.sv */
`timescale 1ns/100ps
`include "term_defines.svh"

module line_edit_data (
	input  term_pkg::line_t cur_line,
	input  term_pkg::cell_t fill,
	input  term_pkg::col_t  col_start,
	input  term_pkg::col_t  col_end,  // inclusive
	output term_pkg::line_t set_line,
	output term_pkg::line_t move_line
);

	logic [`TB_COL_WIDTH:0] span; // cells removed by the shift

	assign span = {1'b0, col_end} - {1'b0, col_start} + 1'b1;

	genvar i;
	generate
		for (i = 0; i < `TB_COLUMNS; i++)
		begin : g_col
			localparam logic [`TB_COL_WIDTH:0] COL = i;

			logic [`TB_COL_WIDTH:0] src;  // source column for the shift
			logic                   in_range;
			term_pkg::cell_t        cur_cell;
			term_pkg::cell_t        src_cell;

			assign cur_cell = cur_line[i*`TB_CELL_WIDTH +: `TB_CELL_WIDTH];
			assign in_range = (COL >= {1'b0, col_start}) && (COL <= {1'b0, col_end});
			assign src      = COL + span;

			// past the right edge the line fills with blanks
			assign src_cell = (src < `TB_COLUMNS)
				? cur_line[src[`TB_COL_WIDTH-1:0]*`TB_CELL_WIDTH +: `TB_CELL_WIDTH]
				: `TB_BLANK_CELL;

			assign set_line[i*`TB_CELL_WIDTH +: `TB_CELL_WIDTH]  = in_range ? fill : cur_cell;
			assign move_line[i*`TB_CELL_WIDTH +: `TB_CELL_WIDTH] =
				(COL < {1'b0, col_start}) ? cur_cell : src_cell;
		end
	endgenerate

endmodule

/* src/text_control.sv */
`timescale 1ns/100ps
`include "term_defines.svh"

module text_control (
	input  logic             clk,
	input  logic             rst,
	input  logic             cmd_valid,
	input  term_pkg::cmd_t   cmd,
	input  term_pkg::count_t cmd_pn,
	input  term_pkg::char_t  cmd_char,
	input  term_pkg::attr_t  cmd_attr,
	input  term_pkg::row_t   cursor_row,
	input  term_pkg::col_t   cursor_col,
	output logic             busy,
	text_ram_if.client       ram
);

	term_pkg::edit_state_t state;

	// line edit
	term_pkg::row_t  edit_row;
	term_pkg::col_t  col_start;
	term_pkg::col_t  col_end;
	term_pkg::cell_t fill_cell;
	logic            edit_move;   // shift left instead of range set
	term_pkg::line_t line_buf;    // line waiting to be written
	term_pkg::line_t set_line;
	term_pkg::line_t move_line;

	// scroll and clear
	term_pkg::row_t  scroll_src;
	term_pkg::row_t  scroll_dst;
	term_pkg::row_t  scroll_last; // final destination row
	logic            scroll_down; // insert moves lines down
	term_pkg::row_t  fill_row;
	term_pkg::row_t  fill_last;

	// decode helpers
	term_pkg::char_t        put_char;
	term_pkg::count_t       pn_eff;
	term_pkg::count_t       line_room; // cursor row to bottom
	term_pkg::count_t       col_room;  // cursor column to line end
	logic [`TB_ROW_WIDTH:0] line_n;
	term_pkg::col_t         del_end;
	logic                   scroll_moves;

	assign put_char     = (cmd_char == 8'h00) ? 8'h20 : cmd_char; // NUL prints as space
	assign pn_eff       = (cmd_pn == 8'd0) ? 8'd1 : cmd_pn;       // count of 0 means 1
	assign line_room    = term_pkg::count_t'(`TB_LINES - cursor_row);
	assign col_room     = term_pkg::count_t'(`TB_COLUMNS - cursor_col);
	assign line_n       = (pn_eff > line_room) ? line_room[`TB_ROW_WIDTH:0]
	                                           : pn_eff[`TB_ROW_WIDTH:0];
	assign del_end      = (pn_eff >= col_room) ? term_pkg::col_t'(`TB_COLUMNS - 1)
	                                           : term_pkg::col_t'(cursor_col + pn_eff - 8'd1);
	assign scroll_moves = line_n < line_room;

	line_edit_data u_edit_data (
		.cur_line  (ram.rdata),
		.fill      (fill_cell),
		.col_start (col_start),
		.col_end   (col_end),
		.set_line  (set_line),
		.move_line (move_line)
	);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			state <= term_pkg::ST_INIT;
		else
		begin
			case (state)
				term_pkg::ST_INIT:
				begin
					fill_row  <= '0;
					fill_last <= term_pkg::row_t'(`TB_LINES - 1);
					state     <= term_pkg::ST_FILL;
				end
				term_pkg::ST_IDLE:
					if (cmd_valid)
					begin
						edit_row <= cursor_row;
						case (cmd)
							term_pkg::PUT_CHAR:
								if (put_char >= 8'h20) // other control codes do nothing
								begin
									fill_cell <= {cmd_attr, put_char};
									col_start <= cursor_col;
									col_end   <= cursor_col;
									edit_move <= 1'b0;
									state     <= term_pkg::ST_LINE_RD;
								end
							term_pkg::ERASE_LINE:
								if (cmd_pn <= 8'd2)
								begin
									fill_cell <= `TB_BLANK_CELL;
									col_start <= (cmd_pn == 8'd0) ? cursor_col : '0;
									col_end   <= (cmd_pn == 8'd1) ? cursor_col
									                              : term_pkg::col_t'(`TB_COLUMNS - 1);
									edit_move <= 1'b0;
									state     <= term_pkg::ST_LINE_RD;
								end
							term_pkg::DELETE_CHARS:
							begin
								col_start <= cursor_col;
								col_end   <= del_end;
								edit_move <= 1'b1;
								state     <= term_pkg::ST_LINE_RD;
							end
							term_pkg::ERASE_DISPLAY:
								if (cmd_pn <= 8'd2)
								begin
									fill_row  <= (cmd_pn == 8'd0) ? cursor_row : '0;
									fill_last <= (cmd_pn == 8'd1) ? cursor_row
									                              : term_pkg::row_t'(`TB_LINES - 1);
									state     <= term_pkg::ST_FILL;
								end
							term_pkg::INSERT_LINES, term_pkg::DELETE_LINES:
							begin
								scroll_down <= (cmd == term_pkg::INSERT_LINES);
								if (!scroll_moves)
								begin
									// every line below the cursor goes, just blank them
									fill_row  <= cursor_row;
									fill_last <= term_pkg::row_t'(`TB_LINES - 1);
									state     <= term_pkg::ST_FILL;
								end
								else if (cmd == term_pkg::INSERT_LINES)
								begin
									scroll_dst  <= term_pkg::row_t'(`TB_LINES - 1); // bottom up
									scroll_src  <= term_pkg::row_t'(`TB_LINES - 1 - line_n);
									scroll_last <= term_pkg::row_t'(cursor_row + line_n);
									fill_row    <= cursor_row;
									fill_last   <= term_pkg::row_t'(cursor_row + line_n - 1);
									state       <= term_pkg::ST_SCROLL_RD;
								end
								else
								begin
									scroll_dst  <= cursor_row; // top down
									scroll_src  <= term_pkg::row_t'(cursor_row + line_n);
									scroll_last <= term_pkg::row_t'(`TB_LINES - 1 - line_n);
									fill_row    <= term_pkg::row_t'(`TB_LINES - line_n);
									fill_last   <= term_pkg::row_t'(`TB_LINES - 1);
									state       <= term_pkg::ST_SCROLL_RD;
								end
							end
							default:
								state <= term_pkg::ST_IDLE;
						endcase
					end
				term_pkg::ST_LINE_RD:
					if (ram.gnt)
						state <= term_pkg::ST_LINE_WAIT;
				term_pkg::ST_LINE_WAIT:
					if (ram.rvalid)
					begin
						line_buf <= edit_move ? move_line : set_line;
						state    <= term_pkg::ST_LINE_WR;
					end
				term_pkg::ST_LINE_WR:
					if (ram.gnt)
						state <= term_pkg::ST_IDLE;
				term_pkg::ST_SCROLL_RD:
					if (ram.gnt)
						state <= term_pkg::ST_SCROLL_WAIT;
				term_pkg::ST_SCROLL_WAIT:
					if (ram.rvalid)
					begin
						line_buf <= ram.rdata;
						state    <= term_pkg::ST_SCROLL_WR;
					end
				term_pkg::ST_SCROLL_WR:
					if (ram.gnt)
					begin
						if (scroll_dst == scroll_last)
							state <= term_pkg::ST_FILL; // now blank the vacated lines
						else
						begin
							scroll_dst <= scroll_down ? scroll_dst - 1'b1 : scroll_dst + 1'b1;
							scroll_src <= scroll_down ? scroll_src - 1'b1 : scroll_src + 1'b1;
							state      <= term_pkg::ST_SCROLL_RD;
						end
					end
				term_pkg::ST_FILL:
					if (ram.gnt)
					begin
						if (fill_row == fill_last)
							state <= term_pkg::ST_IDLE;
						else
							fill_row <= fill_row + 1'b1;
					end
				default:
					state <= term_pkg::ST_IDLE;
			endcase
		end
	end

	assign busy = (state != term_pkg::ST_IDLE);

	// request follows the state, so it holds until granted
	always_comb
	begin
		ram.req   = 1'b0;
		ram.we    = 1'b0;
		ram.addr  = edit_row;
		ram.wdata = line_buf;
		case (state)
			term_pkg::ST_LINE_RD:
				ram.req = 1'b1;
			term_pkg::ST_LINE_WR:
			begin
				ram.req = 1'b1;
				ram.we  = 1'b1;
			end
			term_pkg::ST_SCROLL_RD:
			begin
				ram.req  = 1'b1;
				ram.addr = scroll_src;
			end
			term_pkg::ST_SCROLL_WR:
			begin
				ram.req  = 1'b1;
				ram.we   = 1'b1;
				ram.addr = scroll_dst;
			end
			term_pkg::ST_FILL:
			begin
				ram.req   = 1'b1;
				ram.we    = 1'b1;
				ram.addr  = fill_row;
				ram.wdata = {`TB_COLUMNS{`TB_BLANK_CELL}};
			end
			default:
				ram.req = 1'b0;
		endcase
	end

	a_write_in_range: assert property (@(posedge clk) disable iff (rst)
		(ram.req && ram.we) |-> (ram.addr < `TB_LINES));

endmodule

/* src/line_scanner.sv */
`timescale 1ns/100ps
`include "term_defines.svh"

module line_scanner (
	input  logic            clk,
	input  logic            rst,
	input  logic            scan_req,
	input  term_pkg::row_t  scan_row,
	output logic            scan_busy,
	output logic            scan_valid,
	output term_pkg::line_t scan_line,
	text_ram_if.client      ram
);

	logic           start;   // accepted request this cycle
	logic           pend;    // request lost arbitration, still waiting
	logic           busy_q;
	logic           valid_q;
	term_pkg::row_t row_q;

	assign start = scan_req && !busy_q;

	// ask in the request cycle itself, then hold the latched row
	assign ram.req   = start || pend;
	assign ram.addr  = pend ? row_q : scan_row;
	assign ram.we    = 1'b0;   // read only client
	assign ram.wdata = '0;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			busy_q  <= 1'b0;
			pend    <= 1'b0;
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= ram.rvalid;
			if (start)
			begin
				busy_q <= 1'b1;
				pend   <= !ram.gnt;
			end
			else if (ram.gnt)
				pend <= 1'b0;
			if (ram.rvalid)
				busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
			row_q <= scan_row;
		if (ram.rvalid)
			scan_line <= ram.rdata;
	end

	assign scan_busy  = busy_q;
	assign scan_valid = valid_q;

endmodule

/* src/text_buffer_top.sv */
`timescale 1ns/100ps
`include "term_defines.svh"

module text_buffer_top (
	input  logic             clk,
	input  logic             rst,
	input  logic             cmd_valid,
	input  term_pkg::cmd_t   cmd,
	input  term_pkg::count_t cmd_pn,
	input  term_pkg::char_t  cmd_char,
	input  term_pkg::attr_t  cmd_attr,
	input  term_pkg::row_t   cursor_row,
	input  term_pkg::col_t   cursor_col,
	output logic             busy,
	input  logic             scan_req,
	input  term_pkg::row_t   scan_row,
	output logic             scan_busy,
	output logic             scan_valid,
	output term_pkg::line_t  scan_line
);

	text_ram_if edit_bus ();
	text_ram_if scan_bus ();

	logic            ram_we;
	term_pkg::row_t  ram_addr;
	term_pkg::line_t ram_wdata;
	term_pkg::line_t ram_rdata;

	text_control u_control (
		.clk        (clk),
		.rst        (rst),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.cmd_pn     (cmd_pn),
		.cmd_char   (cmd_char),
		.cmd_attr   (cmd_attr),
		.cursor_row (cursor_row),
		.cursor_col (cursor_col),
		.busy       (busy),
		.ram        (edit_bus.client)
	);

	line_scanner u_scanner (
		.clk        (clk),
		.rst        (rst),
		.scan_req   (scan_req),
		.scan_row   (scan_row),
		.scan_busy  (scan_busy),
		.scan_valid (scan_valid),
		.scan_line  (scan_line),
		.ram        (scan_bus.client)
	);

	text_ram_arbiter u_arbiter (
		.clk       (clk),
		.rst       (rst),
		.edit      (edit_bus.arbiter),
		.scan      (scan_bus.arbiter),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata)
	);

	text_ram u_ram (
		.clk   (clk),
		.we    (ram_we),
		.addr  (ram_addr),
		.wdata (ram_wdata),
		.rdata (ram_rdata)
	);

endmodule

/* verification/text_buffer_tb.sv */
`timescale 1ns/100ps
`include "term_defines.svh"

module text_buffer_tb;

	localparam int N_PUT       = 200;
	localparam int N_LINE      = 48;
	localparam int N_SCREEN    = 36;
	localparam int N_CONC      = 32;
	localparam int REFILL      = 4;   // puts before each erase or scroll
	localparam int TOTAL_CMDS  = N_PUT + (N_LINE + N_SCREEN) * (REFILL + 1) + 2 * N_CONC;
	localparam int CYCLE_BOUND = 120; // worst scroll plus a full screen scan
	localparam int LINES       = `TB_LINES;
	localparam int COLS        = `TB_COLUMNS;

	logic                    clk;
	logic                    rst;
	logic                    cmd_valid;
	term_pkg::cmd_t          cmd;
	term_pkg::count_t        cmd_pn;
	term_pkg::char_t         cmd_char;
	term_pkg::attr_t         cmd_attr;
	term_pkg::row_t          cursor_row;
	term_pkg::col_t          cursor_col;
	logic                    busy;
	logic                    scan_req;
	term_pkg::row_t          scan_row;
	logic                    scan_busy;
	logic                    scan_valid;
	term_pkg::line_t         scan_line;

	logic [`TB_CELL_WIDTH-1:0] model [LINES][COLS]; // expected screen
	integer seed;
	int     checks;
	int     errors;
	int     tests_run;
	int     tests_failed;

	text_buffer_top UUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		#(TOTAL_CMDS * CYCLE_BOUND * 10);
		$display("timeout: the DUT stopped responding before all tests finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

	function int rand_below(input int n);
		rand_below = $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [`TB_LINE_WIDTH-1:0] model_line(input int row);
		logic [`TB_LINE_WIDTH-1:0] l;
		for (int k = 0; k < COLS; k++)
			l[k*`TB_CELL_WIDTH +: `TB_CELL_WIDTH] = model[row][k];
		return l;
	endfunction

	task automatic check_value(input logic [`TB_LINE_WIDTH-1:0] actual,
		input logic [`TB_LINE_WIDTH-1:0] expected, input string what);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("FAILED at %0t: %s, got %h expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic copy_model_row(input int dst, input int src);
		for (int k = 0; k < COLS; k++)
			model[dst][k] = model[src][k];
	endtask

	task automatic blank_model_row(input int row);
		for (int k = 0; k < COLS; k++)
			model[row][k] = `TB_BLANK_CELL;
	endtask

	// terminal rules, written out cell by cell
	task automatic apply_to_model(input term_pkg::cmd_t c, input int pn, input logic [7:0] ch,
		input logic [7:0] attr, input int row, input int col);
		int n;
		int lo;
		int hi;
		logic [7:0] pc;
		n = (pn == 0) ? 1 : pn; // a count of 0 acts as 1
		case (c)
			term_pkg::PUT_CHAR:
			begin
				pc = (ch == 8'h00) ? 8'h20 : ch;
				if (pc >= 8'h20)
					model[row][col] = {attr, pc};
			end
			term_pkg::ERASE_LINE:
				if (pn <= 2)
				begin
					lo = (pn == 0) ? col : 0;
					hi = (pn == 1) ? col : COLS - 1;
					for (int k = lo; k <= hi; k++)
						model[row][k] = `TB_BLANK_CELL;
				end
			term_pkg::DELETE_CHARS:
			begin
				if (n > COLS - col)
					n = COLS - col;
				for (int k = col; k < COLS; k++)
					model[row][k] = (k + n < COLS) ? model[row][k + n] : `TB_BLANK_CELL;
			end
			term_pkg::ERASE_DISPLAY:
				if (pn <= 2)
				begin
					lo = (pn == 0) ? row : 0;
					hi = (pn == 1) ? row : LINES - 1;
					for (int r = lo; r <= hi; r++)
						blank_model_row(r);
				end
			term_pkg::INSERT_LINES:
			begin
				if (n > LINES - row)
					n = LINES - row;
				for (int r = LINES - 1; r >= row + n; r--)
					copy_model_row(r, r - n);
				for (int r = row; r < row + n; r++)
					blank_model_row(r);
			end
			term_pkg::DELETE_LINES:
			begin
				if (n > LINES - row)
					n = LINES - row;
				for (int r = row; r <= LINES - 1 - n; r++)
					copy_model_row(r, r + n);
				for (int r = LINES - n; r < LINES; r++)
					blank_model_row(r);
			end
			default:
				n = 0;
		endcase
	endtask

	// one strobe, then wait until the editor is idle again
	task automatic run_command(input term_pkg::cmd_t c, input int pn, input logic [7:0] ch,
		input logic [7:0] attr, input int row, input int col);
		@(negedge clk);
		cmd        = c;
		cmd_pn     = pn;
		cmd_char   = ch;
		cmd_attr   = attr;
		cursor_row = row;
		cursor_col = col;
		cmd_valid  = 1'b1;
		apply_to_model(c, pn, ch, attr, row, col);
		@(negedge clk);
		cmd_valid = 1'b0;
		while (busy)
			@(negedge clk);
	endtask

	task automatic put_random(input int row);
		int k;
		logic [7:0] ch;
		k  = rand_below(4);
		ch = (k == 0) ? 8'h00 : (k == 1) ? rand_below(32) : rand_below(256); // NUL, control, any
		run_command(term_pkg::PUT_CHAR, 0, ch, rand_below(256), row, rand_below(COLS));
	endtask

	task automatic read_row(input int row, output logic [`TB_LINE_WIDTH-1:0] line);
		@(negedge clk);
		scan_req = 1'b1;
		scan_row = row;
		@(negedge clk);
		scan_req = 1'b0;
		check_value(scan_busy, 1'b1, $sformatf("scan_busy after request for row %0d", row));
		while (!scan_valid)
			@(negedge clk);
		check_value(scan_busy, 1'b0, $sformatf("scan_busy with valid for row %0d", row));
		line = scan_line;
	endtask

	task automatic check_screen(input string tag);
		logic [`TB_LINE_WIDTH-1:0] line;
		for (int r = 0; r < LINES; r++)
		begin
			read_row(r, line);
			check_value(line, model_line(r), $sformatf("%s, row %0d", tag, r));
		end
	endtask

	// line edit on one row, a scan of another row and an ignored strobe while it runs
	task automatic concurrent_step(input int idx);
		int r;
		int s;
		int k;
		logic [`TB_LINE_WIDTH-1:0] line;
		r = rand_below(LINES);
		s = (r + 1 + rand_below(LINES - 1)) % LINES;
		k = rand_below(3);
		@(negedge clk);
		cmd        = (k == 0) ? term_pkg::PUT_CHAR : (k == 1) ? term_pkg::ERASE_LINE
		                                          : term_pkg::DELETE_CHARS;
		cmd_pn     = (k == 1) ? rand_below(3) : rand_below(20);
		cmd_char   = 8'h20 + rand_below(95);
		cmd_attr   = rand_below(256);
		cursor_row = r;
		cursor_col = rand_below(COLS);
		cmd_valid  = 1'b1;
		apply_to_model(cmd, cmd_pn, cmd_char, cmd_attr, r, cursor_col);
		@(negedge clk);
		check_value(busy, 1'b1, $sformatf("busy after accepted command %0d", idx));
		cmd        = term_pkg::cmd_t'(rand_below(6)); // must be dropped
		cmd_pn     = rand_below(8);
		cmd_char   = rand_below(256);
		cursor_row = rand_below(LINES);
		cursor_col = rand_below(COLS);
		scan_req   = 1'b1;
		scan_row   = s;
		@(negedge clk);
		cmd_valid = 1'b0;
		scan_req  = 1'b0;
		while (!scan_valid)
			@(negedge clk);
		check_value(scan_line, model_line(s), $sformatf("scan during command %0d, row %0d", idx, s));
		while (busy)
			@(negedge clk);
		read_row(r, line);
		check_value(line, model_line(r), $sformatf("edited row after command %0d", idx));
	endtask

	task automatic report_test(input int num, input string name, input int errors_before);
		tests_run++;
		if (errors != errors_before)
			tests_failed++;
		$display("test %0d %s: %s, %0d errors", num, name,
			(errors == errors_before) ? "ok" : "bad", errors - errors_before);
	endtask

	initial
	begin
		int e;
		int row;
		seed         = 24402;
		checks       = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		rst          = 1'b1;
		cmd_valid    = 1'b0;
		cmd          = term_pkg::PUT_CHAR;
		cmd_pn       = '0;
		cmd_char     = '0;
		cmd_attr     = '0;
		cursor_row   = '0;
		cursor_col   = '0;
		scan_req     = 1'b0;
		scan_row     = '0;
		for (int r = 0; r < LINES; r++)
			blank_model_row(r);
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		e = errors;
		while (busy)
			@(negedge clk); // power-on clear
		check_screen("blank after reset");
		report_test(1, "reset clear", e);

		e = errors;
		for (int i = 0; i < N_PUT; i++)
			put_random(rand_below(LINES));
		check_screen("after put_char");
		report_test(2, "put_char", e);

		e = errors;
		for (int i = 0; i < N_LINE; i++)
		begin
			row = rand_below(LINES);
			repeat (REFILL) put_random(row);
			if (i % 2 == 0)
				run_command(term_pkg::ERASE_LINE, (i / 2) % 4, 0, 0, row, rand_below(COLS));
			else
				run_command(term_pkg::DELETE_CHARS, rand_below(24), 0, 0, row, rand_below(COLS));
			check_screen($sformatf("line edit %0d", i));
		end
		report_test(3, "erase and delete in line", e);

		e = errors;
		for (int i = 0; i < N_SCREEN; i++)
		begin
			repeat (REFILL) put_random(rand_below(LINES));
			row = rand_below(LINES);
			case (i % 3)
				0: run_command(term_pkg::ERASE_DISPLAY, (i / 3) % 4, 0, 0, row, rand_below(COLS));
				1: run_command(term_pkg::INSERT_LINES, rand_below(10), 0, 0, row, rand_below(COLS));
				default:
					run_command(term_pkg::DELETE_LINES, rand_below(10), 0, 0, row, rand_below(COLS));
			endcase
			check_screen($sformatf("screen edit %0d", i));
		end
		report_test(4, "erase display and scroll", e);

		e = errors;
		for (int i = 0; i < N_CONC; i++)
			concurrent_step(i);
		check_screen("after concurrent scans");
		report_test(5, "scan while busy", e);

		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* flist.f */
+incdir+src
src/term_pkg.sv
src/text_ram_if.sv
src/text_ram.sv
src/text_ram_arbiter.sv
src/line_edit_data.sv
src/text_control.sv
src/line_scanner.sv
src/text_buffer_top.sv
verification/text_buffer_tb.sv
